/* btb_top.f */
hdl/btb_pkg.sv
hdl/bus_pkg.sv
hdl/btb_ctrl_if.sv
hdl/btb_victim_select.sv
hdl/btb_set_array.sv
hdl/btb_csr.sv
hdl/btb_top.sv
tb/btb_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the btb testbench with verilator, run it into sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module btb_tb \
    -f btb_top.f -Mdir obj_dir -o btb_sim || exit 1
./obj_dir/btb_sim > sim.log 2>&1
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || exit 1
exit 0

/* tb/btb_tb.sv */
`timescale 1ns/100ps

module btb_tb
    import btb_pkg::*;
    import bus_pkg::*;
();

    // the tests take about 2,500 cycles
    localparam int cycle_limit = 4000;
    localparam int pool_size = 24;

    logic clock = 1'b0;
    logic reset;
    addr_t fetch_pc_0, fetch_pc_1, target_pc_0, target_pc_1;
    btb_hits_t hits;
    logic resolve_valid;
    addr_t resolve_branch_pc, resolve_target_pc;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w, wb_dat_r;

    // reference model of the array and the register block
    logic m_valid [btb_sets][btb_ways];
    btb_tag_t m_tag [btb_sets][btb_ways];
    addr_t m_target [btb_sets][btb_ways];
    int m_rank [btb_sets][btb_ways];
    logic m_enable, m_flush, m_ack;
    wb_data_t m_hit_count, m_update_count;

    logic [31:0] lfsr_state = 32'he8a1_25d1;
    int cycles = 0;
    string test_name = "reset";
    addr_t pool [pool_size];

    btb_top uut (.*);

    always #2 clock = ~clock;

    // fibonacci lfsr over taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // way holding a valid copy of the tag or -1 when absent
    function automatic int find_tag(int set, btb_tag_t tag);
        for (int w = 0; w < btb_ways; w++) begin
            if (m_valid[set][w] && (m_tag[set][w] == tag)) return w;
        end
        return -1;
    endfunction

    // same tag, else lowest free way, else the oldest
    function automatic int pick_way(int set, btb_tag_t tag);
        int way;
        way = find_tag(set, tag);
        for (int w = 0; w < btb_ways && way < 0; w++) begin
            if (!m_valid[set][w]) way = w;
        end
        for (int w = 0; w < btb_ways && way < 0; w++) begin
            if (m_rank[set][w] == 0) way = w;
        end
        return way;
    endfunction

    task automatic train_model(addr_t pc, addr_t target);
        int set;
        int way;
        int pivot;
        set = int'(pc[4:2]);
        way = pick_way(set, pc[31:5]);
        // fill or eviction pivots at zero
        pivot = (find_tag(set, pc[31:5]) >= 0) ? m_rank[set][way] : 0;
        for (int w = 0; w < btb_ways; w++) begin
            if (m_valid[set][w] && (m_rank[set][w] > pivot)) m_rank[set][w]--;
        end
        m_valid[set][way] = 1'b1;
        m_tag[set][way] = pc[31:5];
        m_target[set][way] = target;
        m_rank[set][way] = btb_ways - 1;
    endtask

    // {hit, target} for a pc including this cycle's training write
    function automatic logic [32:0] predict(addr_t pc);
        int set;
        int way;
        int victim;
        set = int'(pc[4:2]);
        victim = -1;
        if (!m_enable || m_flush) return '0;
        if (resolve_valid && (int'(resolve_branch_pc[4:2]) == set)) begin
            victim = pick_way(set, resolve_branch_pc[31:5]);
            if (resolve_branch_pc[31:5] == pc[31:5]) return {1'b1, resolve_target_pc};
        end
        way = find_tag(set, pc[31:5]);
        // an evicted way no longer hits
        if (way >= 0 && way != victim) return {1'b1, m_target[set][way]};
        return '0;
    endfunction

    function automatic wb_data_t model_reg(wb_addr_t adr);
        case (adr)
            4'h0: return {31'b0, m_enable};
            4'h4: return m_hit_count;
            4'h8: return m_update_count;
            4'hc: return {16'd4, 16'd8};
            default: return '0;
        endcase
    endfunction

    // model follows the edge with the pre-edge inputs
    always @(posedge clock) begin
        logic [32:0] p0, p1;
        logic req;
        p0 = predict(fetch_pc_0);
        p1 = predict(fetch_pc_1);
        req = wb_cyc && wb_stb && !m_ack && !reset;
        if (req && wb_we && (wb_adr == 4'h4)) m_hit_count = '0;
        else m_hit_count = m_hit_count + wb_data_t'(p0[32]) + wb_data_t'(p1[32]);
        if (req && wb_we && (wb_adr == 4'h8)) m_update_count = '0;
        else if (resolve_valid && m_enable && !m_flush) m_update_count++;
        if (m_flush || reset) begin
            for (int s = 0; s < btb_sets; s++) begin
                for (int w = 0; w < btb_ways; w++) begin
                    m_valid[s][w] = 1'b0;
                    m_rank[s][w] = 0;
                end
            end
        end else if (resolve_valid && m_enable) begin
            train_model(resolve_branch_pc, resolve_target_pc);
        end
        m_flush = req && wb_we && (wb_adr == 4'h0) && wb_dat_w[1];
        if (req && wb_we && (wb_adr == 4'h0)) m_enable = wb_dat_w[0];
        m_ack = req;
        if (reset) begin
            m_enable = 1'b0;
            m_hit_count = '0;
            m_update_count = '0;
        end
    end

    task automatic check_target(string name, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "wrong target");
        end
    endtask

    task automatic check_hits(string name, btb_hits_t expected, btb_hits_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "wrong hit flags");
        end
    endtask

    task automatic check_reg(string name, wb_data_t expected, wb_data_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "wrong register value");
        end
    endtask

    task automatic check_ack(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %b actual %b", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "wrong acknowledge");
        end
    endtask

    // both fetch ports and the bus ack checked mid cycle
    always @(negedge clock) begin
        logic [32:0] p0, p1;
        if (!reset) begin
            p0 = predict(fetch_pc_0);
            p1 = predict(fetch_pc_1);
            check_hits(test_name, {p1[32], p0[32]}, hits);
            if (p0[32]) check_target(test_name, p0[31:0], target_pc_0);
            if (p1[32]) check_target(test_name, p1[31:0], target_pc_1);
            check_ack(test_name, m_ack, wb_ack);
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #0.5;
    endtask

    // one classic cycle with read data checked against the model
    task automatic bus_cycle(logic we, wb_addr_t adr, wb_data_t data, output wb_data_t rdata);
        wb_data_t expected;
        int waited;
        resolve_valid = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        expected = model_reg(adr);
        waited = 0;
        next_cycle();
        while (!wb_ack) begin
            waited++;
            if (waited > 8) begin
                $display("no acknowledge from the register block at offset %h", adr);
                $display("Test failures found");
                $fatal(1, "bus hang");
            end
            next_cycle();
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        if (!we) check_reg(test_name, expected, rdata);
        // leave with ack low
        next_cycle();
    endtask

    task automatic probe(addr_t pc0, addr_t pc1, btb_hits_t expected);
        fetch_pc_0 = pc0;
        fetch_pc_1 = pc1;
        resolve_valid = 1'b0;
        @(negedge clock);
        check_hits(test_name, expected, hits);
        next_cycle();
    endtask

    task automatic train(addr_t branch, addr_t target);
        resolve_valid = 1'b1;
        resolve_branch_pc = branch;
        resolve_target_pc = target;
        next_cycle();
        resolve_valid = 1'b0;
    endtask

    // lookups from the pool with optional training of pool pcs
    task automatic random_traffic(int count, logic allow_train);
        int slot;
        for (int i = 0; i < count; i++) begin
            resolve_valid = 1'b0;
            if (allow_train && take_bits(1) != 0) begin
                slot = int'(take_bits(5)) % pool_size;
                if (take_bits(1) != 0) pool[slot] = take_bits(32);
                resolve_valid = 1'b1;
                resolve_branch_pc = pool[slot];
                resolve_target_pc = take_bits(32);
            end
            fetch_pc_0 = pool[int'(take_bits(5)) % pool_size];
            // port 1 sometimes reads the branch just trained
            if (resolve_valid && take_bits(1) != 0) fetch_pc_1 = resolve_branch_pc;
            else fetch_pc_1 = pool[int'(take_bits(5)) % pool_size];
            next_cycle();
        end
        resolve_valid = 1'b0;
    endtask

    initial begin
        wb_data_t data;
        addr_t rpc [5];
        btb_tag_t base;
        addr_t new_target;
        reset = 1'b1;
        fetch_pc_0 = '0;
        fetch_pc_1 = '0;
        resolve_valid = 1'b0;
        resolve_branch_pc = '0;
        resolve_target_pc = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        for (int i = 0; i < pool_size; i++) pool[i] = take_bits(32);
        repeat (2) @(posedge clock);
        #0.5;
        reset = 1'b0;

        // everything misses and registers hold their reset values
        random_traffic(100, 1'b0);
        bus_cycle(1'b0, reg_ctrl, '0, data);
        check_reg(test_name, 32'h0, data);
        bus_cycle(1'b0, reg_hit_count, '0, data);
        check_reg(test_name, 32'h0, data);
        bus_cycle(1'b0, reg_update_count, '0, data);
        check_reg(test_name, 32'h0, data);
        bus_cycle(1'b0, reg_geometry, '0, data);
        check_reg(test_name, 32'h0004_0008, data);

        test_name = "train";
        bus_cycle(1'b1, reg_ctrl, 32'h1, data);
        random_traffic(800, 1'b1);
        // lookup of the branch under training
        new_target = take_bits(32);
        rpc[0] = take_bits(32);
        fetch_pc_0 = rpc[0];
        fetch_pc_1 = rpc[0];
        train(rpc[0], new_target);
        probe(rpc[0], rpc[0], 2'b11);
        random_traffic(400, 1'b0);

        // five tags in set 5
        test_name = "replace";
        bus_cycle(1'b1, reg_ctrl, 32'h3, data);
        base = btb_tag_t'(take_bits(27));
        for (int i = 0; i < 5; i++) rpc[i] = {base + btb_tag_t'(i), 3'd5, 2'b00};
        for (int i = 0; i < 5; i++) train(rpc[i], take_bits(32));
        probe(rpc[0], rpc[1], 2'b10);
        probe(rpc[2], rpc[3], 2'b11);
        probe(rpc[4], rpc[4], 2'b11);
        // retrained first tag survives and the second goes
        bus_cycle(1'b1, reg_ctrl, 32'h3, data);
        for (int i = 0; i < 4; i++) train(rpc[i], take_bits(32));
        train(rpc[0], take_bits(32));
        train(rpc[4], take_bits(32));
        probe(rpc[0], rpc[1], 2'b01);
        probe(rpc[2], rpc[3], 2'b11);
        new_target = take_bits(32);
        train(rpc[2], new_target);
        fetch_pc_0 = rpc[2];
        fetch_pc_1 = rpc[4];
        @(negedge clock);
        check_target(test_name, new_target, target_pc_0);
        next_cycle();
        probe(rpc[0], rpc[3], 2'b11);

        test_name = "disable";
        bus_cycle(1'b1, reg_ctrl, 32'h0, data);
        random_traffic(300, 1'b1);
        probe(rpc[0], rpc[3], 2'b00);
        bus_cycle(1'b1, reg_ctrl, 32'h1, data);
        probe(rpc[0], rpc[3], 2'b11);
        probe(rpc[2], rpc[4], 2'b11);
        random_traffic(200, 1'b0);
        bus_cycle(1'b1, reg_ctrl, 32'h3, data);
        probe(rpc[0], rpc[3], 2'b00);
        random_traffic(100, 1'b0);

        test_name = "counters";
        random_traffic(400, 1'b1);
        bus_cycle(1'b0, reg_hit_count, '0, data);
        bus_cycle(1'b0, reg_update_count, '0, data);
        // flushed and idle so nothing counts after the clears
        bus_cycle(1'b1, reg_ctrl, 32'h3, data);
        bus_cycle(1'b1, reg_hit_count, 32'hffff_ffff, data);
        bus_cycle(1'b1, reg_update_count, '0, data);
        bus_cycle(1'b0, reg_hit_count, '0, data);
        check_reg(test_name, 32'h0, data);
        bus_cycle(1'b0, reg_update_count, '0, data);
        check_reg(test_name, 32'h0, data);
        bus_cycle(1'b0, reg_ctrl, '0, data);
        check_reg(test_name, 32'h1, data);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* hdl/btb_top.sv */
`timescale 1ns/100ps

module btb_top
    import btb_pkg::*;
    import bus_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // fetch side
    input  addr_t     fetch_pc_0,
    input  addr_t     fetch_pc_1,
    output addr_t     target_pc_0,
    output addr_t     target_pc_1,
    output btb_hits_t hits,

    // branch resolution
    input  logic      resolve_valid,
    input  addr_t     resolve_branch_pc,
    input  addr_t     resolve_target_pc,

    // register bus
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack
);

    addr_t fetch_pcs [btb_lookups];
    addr_t fetch_targets [btb_lookups];

    // port 0 and 1 into the lookup arrays
    assign fetch_pcs[0] = fetch_pc_0;
    assign fetch_pcs[1] = fetch_pc_1;
    assign target_pc_0 = fetch_targets[0];
    assign target_pc_1 = fetch_targets[1];

    // enable, flush and event strobes
    btb_ctrl_if ctrl_bus ();

    btb_set_array u_array (
        .clock             (clock),
        .reset             (reset),
        .ctrl              (ctrl_bus.array),
        .pcs               (fetch_pcs),
        .targets           (fetch_targets),
        .hits              (hits),
        .resolve_valid     (resolve_valid),
        .resolve_branch_pc (resolve_branch_pc),
        .resolve_target_pc (resolve_target_pc)
    );

    btb_csr u_csr (
        .clock    (clock),
        .reset    (reset),
        .ctrl     (ctrl_bus.csr),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

/* hdl/btb_csr.sv */
`timescale 1ns/100ps

module btb_csr
    import btb_pkg::*;
    import bus_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    btb_ctrl_if.csr   ctrl,

    // wishbone classic slave
    input  logic      wb_cyc,
    input  logic      wb_stb,
    input  logic      wb_we,
    input  wb_addr_t  wb_adr,
    input  wb_data_t  wb_dat_w,
    output wb_data_t  wb_dat_r,
    output logic      wb_ack
);

    logic request;
    logic write_req;
    logic enable_q;
    logic flush_q;
    wb_data_t hit_count;
    wb_data_t update_count;
    wb_data_t hit_incr;
    wb_data_t geometry;
    wb_data_t read_data;

    // new request only while no ack is out
    assign request = wb_cyc && wb_stb && !wb_ack;
    assign write_req = request && wb_we;

    // ways in the upper half, sets in the lower half
    assign geometry = {16'(btb_ways), 16'(btb_sets)};

    // single cycle ack, no wait states
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= request;
        end
    end

    // control bits
    always_ff @(posedge clock) begin
        if (reset) begin
            enable_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            // flush lives for exactly the ack cycle
            flush_q <= write_req && (wb_adr == reg_ctrl) && wb_dat_w[ctrl_flush_bit];
            if (write_req && (wb_adr == reg_ctrl)) begin
                enable_q <= wb_dat_w[ctrl_enable_bit];
            end
        end
    end

    assign ctrl.enable = enable_q;
    assign ctrl.flush = flush_q;

    // number of ports that hit this cycle
    always_comb begin
        hit_incr = '0;
        for (int i = 0; i < btb_lookups; i++) begin
            hit_incr = hit_incr + wb_data_t'(ctrl.lookup_hits[i]);
        end
    end

    // statistics, a write clears and wins over the increment
    always_ff @(posedge clock) begin
        if (reset) begin
            hit_count <= '0;
            update_count <= '0;
        end else begin
            if (write_req && (wb_adr == reg_hit_count)) begin
                hit_count <= '0;
            end else begin
                hit_count <= hit_count + hit_incr;
            end
            if (write_req && (wb_adr == reg_update_count)) begin
                update_count <= '0;
            end else begin
                update_count <= update_count + wb_data_t'(ctrl.update_fire);
            end
        end
    end

    // read mux
    always_comb begin
        read_data = '0;
        case (wb_adr)
            reg_ctrl: read_data[ctrl_enable_bit] = enable_q;
            reg_hit_count: read_data = hit_count;
            reg_update_count: read_data = update_count;
            reg_geometry: read_data = geometry;
            default: read_data = '0;
        endcase
    end

    // sampled with the request, held through the ack
    always_ff @(posedge clock) begin
        if (request) begin
            wb_dat_r <= read_data;
        end
    end

endmodule

/* hdl/btb_set_array.sv */
`timescale 1ns/100ps

module btb_set_array
    import btb_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    btb_ctrl_if.array        ctrl,

    // fetch side
    input  addr_t            pcs [btb_lookups],
    output addr_t            targets [btb_lookups],
    output btb_hits_t        hits,

    // training side
    input  logic             resolve_valid,
    input  addr_t            resolve_branch_pc,
    input  addr_t            resolve_target_pc
);

    // registered state with one packed row of ways per set
    logic [btb_ways-1:0] valid_q [btb_sets];
    btb_tag_t [btb_ways-1:0] tag_q [btb_sets];
    addr_t [btb_ways-1:0] target_q [btb_sets];
    btb_rank_t [btb_ways-1:0] rank_q [btb_sets];

    // next state which lookups also see
    logic [btb_ways-1:0] valid_d [btb_sets];
    btb_tag_t [btb_ways-1:0] tag_d [btb_sets];
    addr_t [btb_ways-1:0] target_d [btb_sets];
    btb_rank_t [btb_ways-1:0] rank_d [btb_sets];

    // training write decode
    logic wr_fire;
    btb_index_t wr_index;
    btb_tag_t wr_tag;

    // per set victim choice
    btb_way_t victim_way [btb_sets];
    logic [btb_sets-1:0] victim_match;
    btb_rank_t old_rank [btb_sets];

    // per port read decode
    btb_index_t rd_index [btb_lookups];
    btb_tag_t rd_tag [btb_lookups];

    // training is dropped while disabled and in the flush cycle
    assign wr_fire = resolve_valid && ctrl.enable && !ctrl.flush;
    assign wr_index = pc_index(resolve_branch_pc);
    assign wr_tag = pc_tag(resolve_branch_pc);

    assign ctrl.update_fire = wr_fire;

    genvar s;
    generate
        for (s = 0; s < btb_sets; s++) begin : g_set
            btb_victim_select u_victim (
                .ways_valid (valid_q[s]),
                .ways_tags  (tag_q[s]),
                .ways_ranks (rank_q[s]),
                .write_tag  (wr_tag),
                .way        (victim_way[s]),
                .tag_match  (victim_match[s])
            );

            // a refresh keeps its own rank as the pivot
            // a fill or an eviction pivots at rank zero
            // invalid ways sit at zero and the evicted way has rank zero
            assign old_rank[s] = victim_match[s] ? rank_q[s][victim_way[s]] : '0;
        end
    endgenerate

    genvar p;
    generate
        for (p = 0; p < btb_lookups; p++) begin : g_port
            assign rd_index[p] = pc_index(pcs[p]);
            assign rd_tag[p] = pc_tag(pcs[p]);
        end
    endgenerate

    // next state of the whole array
    always_comb begin
        valid_d = valid_q;
        tag_d = tag_q;
        target_d = target_q;
        rank_d = rank_q;
        if (ctrl.flush) begin
            // tags and targets stay but nothing is valid any more
            for (int i = 0; i < btb_sets; i++) begin
                valid_d[i] = '0;
                rank_d[i] = '0;
            end
        end else if (wr_fire) begin
            // ways newer than the pivot age by one
            for (int w = 0; w < btb_ways; w++) begin
                if (valid_q[wr_index][w] && (rank_q[wr_index][w] > old_rank[wr_index])) begin
                    rank_d[wr_index][w] = rank_q[wr_index][w] - btb_rank_t'(1);
                end
            end
            // written way becomes the newest
            valid_d[wr_index][victim_way[wr_index]] = 1'b1;
            tag_d[wr_index][victim_way[wr_index]] = wr_tag;
            target_d[wr_index][victim_way[wr_index]] = resolve_target_pc;
            rank_d[wr_index][victim_way[wr_index]] = btb_rank_newest;
        end
    end

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '{default: '0};
            rank_q <= '{default: '0};
        end else begin
            valid_q <= valid_d;
            rank_q <= rank_d;
        end
    end

    // tag and target payload
    always_ff @(posedge clock) begin
        tag_q <= tag_d;
        target_q <= target_d;
    end

    // lookup against next state so a same-cycle training write hits
    always_comb begin
        hits = '0;
        for (int i = 0; i < btb_lookups; i++) begin
            targets[i] = '0;
            for (int w = 0; w < btb_ways; w++) begin
                // at most one way per set holds a given tag
                if (ctrl.enable && valid_d[rd_index[i]][w] &&
                    (tag_d[rd_index[i]][w] == rd_tag[i])) begin
                    hits[i] = 1'b1;
                    targets[i] = target_d[rd_index[i]][w];
                end
            end
        end
    end

    // hit flags also feed the statistics
    assign ctrl.lookup_hits = hits;

endmodule

/* hdl/btb_victim_select.sv */
`timescale 1ns/100ps

module btb_victim_select
    import btb_pkg::*;
(
    input  logic [btb_ways-1:0]     ways_valid,
    input  btb_tag_t [btb_ways-1:0] ways_tags,
    input  btb_rank_t [btb_ways-1:0] ways_ranks,
    input  btb_tag_t                write_tag,
    output btb_way_t                way,
    output logic                    tag_match
);

    btb_way_t match_way;
    btb_way_t free_way;
    btb_way_t oldest_way;
    logic any_free;

    always_comb begin
        tag_match = 1'b0;
        any_free = 1'b0;
        match_way = '0;
        free_way = '0;
        oldest_way = '0;
        // scan downwards so the lowest index wins
        for (int w = btb_ways - 1; w >= 0; w--) begin
            if (ways_valid[w] && (ways_tags[w] == write_tag)) begin
                tag_match = 1'b1;
                match_way = btb_way_t'(w);
            end
            if (!ways_valid[w]) begin
                any_free = 1'b1;
                free_way = btb_way_t'(w);
            end
            // only meaningful once the set is full
            if (ways_valid[w] && (ways_ranks[w] == '0)) begin
                oldest_way = btb_way_t'(w);
            end
        end
    end

    // refresh, then fill, then evict
    assign way = tag_match ? match_way : (any_free ? free_way : oldest_way);

endmodule

/* hdl/btb_ctrl_if.sv */
`timescale 1ns/100ps

interface btb_ctrl_if;

    // from the register block
    logic enable;
    logic flush;

    // event strobes back from the array
    btb_pkg::btb_hits_t lookup_hits;
    logic update_fire;

    modport csr (
        output enable, flush,
        input lookup_hits, update_fire
    );

    modport array (
        input enable, flush,
        output lookup_hits, update_fire
    );

endinterface

/* hdl/bus_pkg.sv */
package bus_pkg;

    // wishbone data and byte address
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0] wb_addr_t;

    // register map, word aligned
    localparam wb_addr_t reg_ctrl = 4'h0;
    localparam wb_addr_t reg_hit_count = 4'h4;
    localparam wb_addr_t reg_update_count = 4'h8;
    localparam wb_addr_t reg_geometry = 4'hc;

    // control register fields
    localparam int ctrl_enable_bit = 0;
    // write-only, reads back as zero
    localparam int ctrl_flush_bit = 1;

endpackage

/* hdl/btb_pkg.sv */
package btb_pkg;

    // fetch width and geometry
    localparam int btb_lookups = 2;
    localparam int btb_sets = 8;
    localparam int btb_ways = 4;

    // pc split, offset bits are dropped
    localparam int btb_offset_bits = 2;
    localparam int btb_index_bits = 3;
    localparam int btb_tag_bits = 32 - btb_index_bits - btb_offset_bits;

    // byte address or pc
    typedef logic [31:0] addr_t;

    // set index and tag fields of a pc
    typedef logic [btb_index_bits-1:0] btb_index_t;
    typedef logic [btb_tag_bits-1:0] btb_tag_t;

    // way number inside a set
    typedef logic [$clog2(btb_ways)-1:0] btb_way_t;

    // recency rank, 0 is the eviction candidate
    typedef logic [$clog2(btb_ways)-1:0] btb_rank_t;

    // one hit flag per fetch port
    typedef logic [btb_lookups-1:0] btb_hits_t;

    // rank given to the way just written
    localparam btb_rank_t btb_rank_newest = btb_rank_t'(btb_ways - 1);

    // index sits right above the offset bits
    function automatic btb_index_t pc_index(addr_t pc);
        return pc[btb_offset_bits +: btb_index_bits];
    endfunction

    // tag is everything above the index
    function automatic btb_tag_t pc_tag(addr_t pc);
        return pc[btb_offset_bits + btb_index_bits +: btb_tag_bits];
    endfunction

endpackage
